// File: Makefile
# Verilator build and run of the console testbench

sim:
	verilator --binary --timing --top-module console_tb -f flist.f \
		--Mdir obj_dir -o console_sim
	./obj_dir/console_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: common/console_pkg.sv
// Console package
// Field layouts of the console control registers, the status word
// returned on the spy bus and the machine cycle states
package console_pkg;

   // Mode register, spy bits 5..2
   typedef struct packed {
      logic promdisable;
      logic trapenb;
      logic stathenb;
      logic errstop;
   } mode_reg_t;

   // Opcode control, spy bits 2..0
   typedef struct packed {
      logic opcinh;
      logic opcclk;
      logic lpc_hold;
   } opc_reg_t;

   // Clock control, spy bits 4..0
   typedef struct packed {
      logic ldstat;
      logic idebug;
      logic nop11;
      logic step;
      logic run;
   } clk_reg_t;

   //////////////////////////////
   // Status word, 16 bits
   //////////////////////////////
   typedef struct packed {
      logic [4:0] reserved;
      logic       promdisabled;
      logic       errstop;
      logic       idebug;
      logic       nop11;
      logic       opcinh;
      logic       opcclk;
      logic       lpc_hold;
      logic       srun;
      logic       ssdone;
      logic       stathalt;
      logic       machrun;
   } status_t;

   // Machine cycle, one instruction per lap
   typedef enum logic [1:0] {
      ST_FETCH  = 2'd0,
      ST_DECODE = 2'd1,
      ST_EXEC   = 2'd2,
      ST_WRITE  = 2'd3
   } mstate_t;

endpackage

// File: common/spy_if.sv
// Spy write interface
// Carries the spy write data and the one-hot register load strobes
// from the spy decoder to the console registers
interface spy_if
   import spy_pkg::*;
();

   spy_word_t wdata;
   logic      ldscratch1;
   logic      ldscratch2;
   logic      ldmode;
   logic      ldopc;
   logic      ldclk;

   modport decoder (
      output wdata,
      output ldscratch1,
      output ldscratch2,
      output ldmode,
      output ldopc,
      output ldclk
   );

   modport console (
      input wdata,
      input ldscratch1,
      input ldscratch2,
      input ldmode,
      input ldopc,
      input ldclk
   );

endinterface

// File: common/spy_pkg.sv
// Spy bus package
// Widths, register addresses and word types of the debug spy bus
// used by the host to write and read the console registers
package spy_pkg;

   localparam int SPY_WIDTH      = 16;
   localparam int SPY_ADDR_WIDTH = 4;

   typedef logic [SPY_WIDTH-1:0]      spy_word_t;
   typedef logic [SPY_ADDR_WIDTH-1:0] spy_addr_t;

   //////////////////////////////
   // Write addresses
   //////////////////////////////
   localparam spy_addr_t SPY_LDSCRATCH1 = 4'd0;
   localparam spy_addr_t SPY_LDSCRATCH2 = 4'd1;
   localparam spy_addr_t SPY_LDMODE     = 4'd2;
   localparam spy_addr_t SPY_LDOPC      = 4'd3;
   localparam spy_addr_t SPY_LDCLK      = 4'd4;

   //////////////////////////////
   // Read addresses
   //////////////////////////////
   localparam spy_addr_t SPY_RD_SCRATCH = 4'd8;
   localparam spy_addr_t SPY_RD_STATUS  = 4'd9;
   localparam spy_addr_t SPY_RD_MODE    = 4'd10;

   // Scratch contents after reset
   localparam spy_word_t SCRATCH_RESET = 16'h1234;

endpackage

// File: flist.f
common/spy_pkg.sv
common/console_pkg.sv
common/spy_if.sv
hw/spy_decode.sv
hw/overlord/overlord.sv
hw/fetch_seq.sv
hw/console_top.sv
verification/console_tb.sv

// File: hw/console_top.sv
// Console top level
// Spy decoder, overlord and fetch sequencer of the console section,
// with the spy bus and control lines brought out as plain ports
module console_top
   import spy_pkg::*;
   import console_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  spy_addr_t spy_addr,
   input  logic      spy_wr,
   input  spy_word_t spy_wdata,
   input  logic      boot,
   input  logic      errhalt,
   input  logic      statstop,
   input  logic      mem_wait,
   input  logic      set_promdisable,
   output spy_word_t spy_rdata,
   output logic      machrun,
   output logic      ssdone,
   output logic      errstop,
   output logic      promdisabled,
   output spy_word_t instr_count,
   output mstate_t   mstate
);

   spy_word_t scratch;
   mode_reg_t mode;
   status_t   status;
   logic      state_fetch;

   spy_if spy_bus ();

   spy_decode u_spy_decode (
      .clk       (clk),
      .reset     (reset),
      .spy_addr  (spy_addr),
      .spy_wr    (spy_wr),
      .spy_wdata (spy_wdata),
      .spy       (spy_bus.decoder),
      .scratch   (scratch),
      .status    (status),
      .mode      (mode),
      .spy_rdata (spy_rdata)
   );

   overlord u_overlord (
      .clk             (clk),
      .reset           (reset),
      .spy             (spy_bus.console),
      .boot            (boot),
      .errhalt         (errhalt),
      .statstop        (statstop),
      .mem_wait        (mem_wait),
      .set_promdisable (set_promdisable),
      .state_fetch     (state_fetch),
      .scratch         (scratch),
      .mode            (mode),
      .status          (status),
      .machrun         (machrun)
   );

   fetch_seq u_fetch_seq (
      .clk         (clk),
      .reset       (reset),
      .machrun     (machrun),
      .state_fetch (state_fetch),
      .mstate      (mstate),
      .instr_count (instr_count)
   );

   // Console lamps taken from the status word
   assign ssdone       = status.ssdone;
   assign errstop      = status.errstop;
   assign promdisabled = status.promdisabled;

endmodule

// File: hw/fetch_seq.sv
// Fetch sequencer
// Steps the four machine cycle states while machrun is high, flags
// the fetch state and counts fetched instructions
module fetch_seq
   import spy_pkg::*;
   import console_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      machrun,
   output logic      state_fetch,
   output mstate_t   mstate,
   output spy_word_t instr_count
);

   mstate_t next_state;

   //////////////////////////////
   // State ring
   //////////////////////////////
   always_comb begin
      case (mstate)
         ST_FETCH:  next_state = ST_DECODE;
         ST_DECODE: next_state = ST_EXEC;
         ST_EXEC:   next_state = ST_WRITE;
         ST_WRITE:  next_state = ST_FETCH;
         default:   next_state = ST_FETCH;
      endcase
   end

   // Halted machine holds its state
   always_ff @(posedge clk) begin
      if (reset) begin
         mstate <= ST_FETCH;
      end else if (machrun) begin
         mstate <= next_state;
      end
   end

   assign state_fetch = machrun && (mstate == ST_FETCH);

   //////////////////////////////
   // Instruction counter
   //////////////////////////////

   // Wraps at 16 bits
   always_ff @(posedge clk) begin
      if (reset) begin
         instr_count <= '0;
      end else if (state_fetch) begin
         instr_count <= instr_count + 1'b1;
      end
   end

endmodule

// File: hw/overlord/overlord.sv
// Overlord
// Console register file of the processor: scratch, mode, opcode control
// and clock control. Synchronizes the run and single-step requests and
// forms machrun, which lets the machine cycle advance.
module overlord
   import spy_pkg::*;
   import console_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   spy_if.console    spy,
   input  logic      boot,
   input  logic      errhalt,
   input  logic      statstop,
   input  logic      mem_wait,
   input  logic      set_promdisable,
   input  logic      state_fetch,
   output spy_word_t scratch,
   output mode_reg_t mode,
   output status_t   status,
   output logic      machrun
);

   opc_reg_t opc;
   clk_reg_t clk_r;
   logic     srun;
   logic     sstep;
   logic     ssdone;
   logic     promdisabled;
   logic     stathalt;

   //////////////////////////////
   // Spy loaded registers
   //////////////////////////////

   // Mode write wins over the PROM disable request
   always_ff @(posedge clk) begin
      if (reset) begin
         mode <= '0;
      end else if (spy.ldmode) begin
         mode <= mode_reg_t'(spy.wdata[5:2]);
      end else if (set_promdisable) begin
         mode.promdisable <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         scratch <= SCRATCH_RESET;
      end else if (spy.ldscratch1 || spy.ldscratch2) begin
         scratch <= spy.wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         opc <= '0;
      end else if (spy.ldopc) begin
         opc <= opc_reg_t'(spy.wdata[2:0]);
      end
   end

   // Boot forces run regardless of a clock control write
   always_ff @(posedge clk) begin
      if (reset) begin
         clk_r <= '0;
      end else begin
         if (spy.ldclk) begin
            clk_r <= clk_reg_t'(spy.wdata[4:0]);
         end
         if (boot) begin
            clk_r.run <= 1'b1;
         end
      end
   end

   //////////////////////////////
   // Run and step control
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         srun         <= 1'b0;
         sstep        <= 1'b0;
         ssdone       <= 1'b0;
         promdisabled <= 1'b0;
      end else begin
         srun         <= clk_r.run;
         sstep        <= clk_r.step;
         promdisabled <= mode.promdisable;
         // Fetch ends the step, a new step edge rearms it
         if (state_fetch) begin
            ssdone <= sstep;
         end else if (!sstep && clk_r.step) begin
            ssdone <= 1'b0;
         end
      end
   end

   assign stathalt = statstop & mode.stathenb;
   assign machrun  = (sstep & ~ssdone) | (srun & ~errhalt & ~mem_wait & ~stathalt);

   always_comb begin
      status              = '0;
      status.promdisabled = promdisabled;
      status.errstop      = mode.errstop;
      status.idebug       = clk_r.idebug;
      status.nop11        = clk_r.nop11;
      status.opcinh       = opc.opcinh;
      status.opcclk       = opc.opcclk;
      status.lpc_hold     = opc.lpc_hold;
      status.srun         = srun;
      status.ssdone       = ssdone;
      status.stathalt     = stathalt;
      status.machrun      = machrun;
   end

endmodule

// File: hw/spy_decode.sv
// Spy decoder
// Turns a host write into a single register load strobe and selects
// the read-back word by register address
module spy_decode
   import spy_pkg::*;
   import console_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  spy_addr_t spy_addr,
   input  logic      spy_wr,
   input  spy_word_t spy_wdata,
   spy_if.decoder    spy,
   input  spy_word_t scratch,
   input  status_t   status,
   input  mode_reg_t mode,
   output spy_word_t spy_rdata
);

   // clk and reset only matter for a registered read path, the
   // current decoder answers within the same cycle

   assign spy.wdata = spy_wdata;

   //////////////////////////////
   // Write strobes
   //////////////////////////////
   always_comb begin
      spy.ldscratch1 = 1'b0;
      spy.ldscratch2 = 1'b0;
      spy.ldmode     = 1'b0;
      spy.ldopc      = 1'b0;
      spy.ldclk      = 1'b0;
      if (spy_wr) begin
         case (spy_addr)
            SPY_LDSCRATCH1: spy.ldscratch1 = 1'b1;
            SPY_LDSCRATCH2: spy.ldscratch2 = 1'b1;
            SPY_LDMODE:     spy.ldmode     = 1'b1;
            SPY_LDOPC:      spy.ldopc      = 1'b1;
            SPY_LDCLK:      spy.ldclk      = 1'b1;
            default:        ;
         endcase
      end
   end

   //////////////////////////////
   // Read-back mux
   //////////////////////////////
   always_comb begin
      case (spy_addr)
         SPY_RD_SCRATCH: spy_rdata = scratch;
         SPY_RD_STATUS:  spy_rdata = status;
         // Mode bits sit at the bottom of the word
         SPY_RD_MODE:    spy_rdata = {{(SPY_WIDTH-4){1'b0}}, mode};
         default:        spy_rdata = '0;
      endcase
   end

endmodule

// File: verification/console_tb.sv
// Console testbench
// Drives the spy bus and control lines of console_top and checks
// read-back, status, run, halt, boot and single-step behavior
module console_tb
   import spy_pkg::*;
   import console_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   logic clk = 1'b0;
   logic reset = 1'b1;
   spy_addr_t spy_addr = '0;
   logic spy_wr = 1'b0;
   spy_word_t spy_wdata = '0;
   logic boot = 1'b0;
   logic errhalt = 1'b0;
   logic statstop = 1'b0;
   logic mem_wait = 1'b0;
   logic set_promdisable = 1'b0;
   spy_word_t spy_rdata;
   spy_word_t instr_count;
   logic machrun;
   logic ssdone;
   logic errstop;
   logic promdisabled;
   mstate_t mstate;
   logic [31:0] seed = 32'ha24ba33a;
   int cycles = 0;

   console_top DUT (.*);

   always #4 clk = ~clk;

   // Limit well above the length of the whole sequence
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= 4000) begin
         $display("SIMULATION FAILED");
         $fatal(1, "Timeout: the test did not finish within 4000 cycles");
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected status word from the shadow registers
   function automatic status_t ref_status(mode_reg_t m, opc_reg_t o, clk_reg_t c,
         logic srun, logic sstep, logic sdone, logic pdis, logic stop, logic eh, logic mw);
      status_t s;
      logic halt;
      s = '0;
      halt = stop & m.stathenb;
      s.promdisabled = pdis;
      s.errstop = m.errstop;
      s.idebug = c.idebug;
      s.nop11 = c.nop11;
      s.opcinh = o.opcinh;
      s.opcclk = o.opcclk;
      s.lpc_hold = o.lpc_hold;
      s.srun = srun;
      s.ssdone = sdone;
      s.stathalt = halt;
      s.machrun = (sstep & ~sdone) | (srun & ~eh & ~mw & ~halt);
      return s;
   endfunction

   // Four machine cycles per instruction
   function automatic spy_word_t ref_count(spy_word_t base, int run_cycles);
      return base + spy_word_t'(run_cycles / 4);
   endfunction

   task automatic check_word(string name, spy_word_t got, spy_word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic check_status(status_t got, status_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED t=%0t status got %h expected %h", $time, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "Mismatch on status");
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic idle(int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic spy_write(spy_addr_t a, spy_word_t d);
      @(negedge clk);
      spy_addr = a;
      spy_wdata = d;
      spy_wr = 1'b1;
      @(negedge clk);
      spy_wr = 1'b0;
   endtask

   task automatic spy_read(spy_addr_t a, output spy_word_t d);
      @(negedge clk);
      spy_addr = a;
      #2 d = spy_rdata;
   endtask

   initial begin
      spy_word_t rd, c0, w;
      mode_reg_t sh_mode;
      opc_reg_t sh_opc;
      mstate_t st0;
      status_t st;
      int gap;
      repeat (16) @(negedge clk);
      reset = 1'b0;
      // After reset
      spy_read(SPY_RD_SCRATCH, rd);
      check_word("scratch", rd, SCRATCH_RESET);
      spy_read(SPY_RD_STATUS, rd);
      check_status(status_t'(rd), '0);
      spy_read(SPY_RD_MODE, rd);
      check_word("mode", rd, '0);
      check_bit("machrun", machrun, 1'b0);
      check_word("instr_count", instr_count, '0);

      //////////////////////////////
      // Register read-back
      //////////////////////////////
      for (int i = 0; i < 8; i++) begin
         seed = lcg_next(seed);
         w = seed[31:16];
         spy_write((i % 2) ? SPY_LDSCRATCH2 : SPY_LDSCRATCH1, w);
         spy_read(SPY_RD_SCRATCH, rd);
         check_word("scratch", rd, w);
         seed = lcg_next(seed);
         sh_mode = mode_reg_t'(seed[21:18]);
         sh_opc = opc_reg_t'(seed[26:24]);
         spy_write(SPY_LDMODE, spy_word_t'(seed[21:16]));
         spy_write(SPY_LDOPC, spy_word_t'(seed[26:24]));
         check_bit("errstop", errstop, sh_mode.errstop);
         spy_read(SPY_RD_MODE, rd);
         check_word("mode", rd, {12'h000, sh_mode});
         spy_read(SPY_RD_STATUS, rd);
         check_status(status_t'(rd), ref_status(sh_mode, sh_opc, '0, 1'b0, 1'b0, 1'b0,
            sh_mode.promdisable, 1'b0, 1'b0, 1'b0));
      end
      spy_write(SPY_LDMODE, '0);
      sh_mode = '0;
      idle(1);
      @(negedge clk);
      set_promdisable = 1'b1;
      @(negedge clk);
      set_promdisable = 1'b0;
      check_bit("promdisabled", promdisabled, 1'b0);
      spy_read(SPY_RD_MODE, rd);
      check_word("mode", rd, 16'h0008);
      check_bit("promdisabled", promdisabled, 1'b1);
      spy_write(SPY_LDMODE, '0);
      idle(1);

      //////////////////////////////
      // Run and halt sources
      //////////////////////////////
      spy_write(SPY_LDCLK, 16'h0001);
      spy_read(SPY_RD_STATUS, rd);
      check_status(status_t'(rd), ref_status(sh_mode, sh_opc, clk_reg_t'(5'b00001),
         1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
      c0 = instr_count;
      idle(16);
      check_word("instr_count", instr_count, ref_count(c0, 16));
      spy_write(SPY_LDMODE, 16'h0008);
      sh_mode = mode_reg_t'(4'b0010);
      for (int k = 0; k < 3; k++) begin
         @(negedge clk);
         errhalt = (k == 0);
         mem_wait = (k == 1);
         statstop = (k == 2);
         @(negedge clk);
         check_bit("machrun", machrun, 1'b0);
         c0 = instr_count;
         st0 = mstate;
         idle(5);
         check_word("instr_count", instr_count, c0);
         check_word("mstate", spy_word_t'(mstate), spy_word_t'(st0));
         errhalt = 1'b0;
         mem_wait = 1'b0;
         statstop = 1'b0;
         idle(8);
         check_word("instr_count", instr_count, ref_count(c0, 8));
         // Two full laps bring the ring back to the same state
         check_word("mstate", spy_word_t'(mstate), spy_word_t'(st0));
      end

      // Boot after run was cleared
      spy_write(SPY_LDCLK, 16'h0000);
      idle(2);
      check_bit("machrun", machrun, 1'b0);
      boot = 1'b1;
      spy_addr = SPY_RD_STATUS;
      @(negedge clk);
      boot = 1'b0;
      #2 st = status_t'(spy_rdata);
      check_bit("srun", st.srun, 1'b0);
      @(negedge clk);
      #2 st = status_t'(spy_rdata);
      check_bit("srun", st.srun, 1'b1);
      check_bit("machrun", machrun, 1'b1);
      spy_write(SPY_LDCLK, 16'h0000);
      idle(2);

      //////////////////////////////
      // Single step
      //////////////////////////////
      for (int s = 0; s < 6; s++) begin
         spy_write(SPY_LDCLK, 16'h0000);
         seed = lcg_next(seed);
         gap = 1 + int'(seed[17:16]);
         idle(gap);
         check_bit("machrun", machrun, 1'b0);
         c0 = instr_count;
         spy_write(SPY_LDCLK, 16'h0002);
         idle(1);
         for (int t = 0; t < 4 && ssdone !== 1'b1; t++)
            idle(1);
         check_bit("ssdone", ssdone, 1'b1);
         check_bit("machrun", machrun, 1'b0);
         // A full lap would reach the next fetch if the step kept running
         idle(4);
         check_word("instr_count", instr_count, c0 + 16'd1);
      end
      spy_read(SPY_RD_STATUS, rd);
      check_status(status_t'(rd), ref_status(sh_mode, sh_opc, clk_reg_t'(5'b00010),
         1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
